/* list.f */
+incdir+logic
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/exceptionUnit.sv
logic/mainFsm.sv
logic/ctrlWordTable.sv
logic/ctrlUnit.sv
testbench/ctrlUnitTb.sv

/* Makefile */
# Verilator build and run of the control unit testbench
VERILATOR ?= verilator
TOP       ?= ctrlUnitTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/ctrl_cases.txt */
// opcode funct ovf eq gt lt | regWr regDst wbSrc pcSrc memWr epcWr cause, all hex, f = none
// first value is the case count; codes follow the enum order in ctrlPkg
19      // 25 cases
00 20 0 0 0 0  1 1 0 f 0 0 0  // add
00 24 0 0 0 0  1 1 0 f 0 0 0  // and
00 2a 0 0 0 0  1 1 5 f 0 0 0  // slt
08 00 0 0 0 0  1 0 0 f 0 0 0  // addi
09 00 0 0 0 0  1 0 0 f 0 0 0  // addiu
0a 00 0 0 0 0  1 0 5 f 0 0 0  // slti
0f 00 0 0 0 0  1 0 3 f 0 0 0  // lui
04 00 0 1 0 0  0 f f 1 0 0 0  // beq taken
04 00 0 0 1 0  0 f f f 0 0 0  // beq not taken
05 00 0 0 0 1  0 f f 1 0 0 0  // bne taken
06 00 0 1 0 0  0 f f 1 0 0 0  // ble taken on eq
07 00 0 0 0 1  0 f f f 0 0 0  // bgt not taken
02 00 0 0 0 0  0 f f 2 0 0 0  // j
03 00 0 0 0 0  1 2 2 2 0 0 0  // jal
00 08 0 0 0 0  0 f f 4 0 0 0  // jr
23 00 0 0 0 0  1 0 1 f 0 0 0  // lw
2b 00 0 0 0 0  0 f f f 1 0 0  // sw
09 00 1 0 0 0  1 0 0 f 0 0 0  // addiu, overflow ignored
00 24 1 0 0 0  1 1 0 f 0 0 0  // and, overflow ignored
00 20 1 0 0 0  0 f f 3 0 1 2  // add overflow
3f 00 0 0 0 0  0 f f 3 0 1 1  // illegal opcode
00 00 0 0 0 0  0 f f 3 0 1 1  // sll is not decoded
00 22 1 0 0 0  0 f f 3 0 1 2  // sub overflow
08 00 1 0 0 0  0 f f 3 0 1 2  // addi overflow
23 00 0 0 0 0  1 0 1 f 0 0 2  // lw, cause register still holds overflow

/* testbench/ctrlUnitTb.sv */
`default_nettype none

`include "ctrl_params.svh"

module ctrlUnitTb import ctrlPkg::*; ();

  localparam int FIELDS    = 13; // words per case line
  localparam int MAX_CASES = 32;
  localparam int MEM_WORDS = 1 + MAX_CASES * FIELDS;
  localparam int NONE      = 15; // code for "no such event in this case"

  logic                 clk = 1'b0;
  logic                 reset;
  logic [`OPCODE_W-1:0] opcode;
  logic [`FUNCT_W-1:0]  funct;
  logic                 overflow;
  logic                 eq;
  logic                 gt;
  logic                 lt;
  logic                 memReady = 1'b0;
  logic                 memValid;
  logic                 memWrite;
  logic                 addrFromAlu;
  logic                 irWrite;
  logic                 pcWrite;
  pcSrcT                pcSrc;
  logic                 regWrite;
  regDstT               regDst;
  wbSrcT                wbSrc;
  aluOpT                aluOp;
  aluSrcAT              aluSrcA;
  aluSrcBT              aluSrcB;
  logic                 epcWrite;
  excCauseT             excCause;

  logic [7:0]  caseMem [0:MEM_WORDS-1];
  int          caseTotal = 0;
  logic        loaded = 1'b0;
  int          errorCount = 0;
  logic [31:0] lfsrState = 32'h6afb;
  logic        memBusy = 1'b0;
  int          waitLeft = 0;

  // running totals that the monitor keeps
  int regWriteCount = 0;
  int pcWriteCount = 0;
  int memWriteCount = 0;
  int epcWriteCount = 0;
  int lastRegDst = NONE;
  int lastWbSrc = NONE;
  int lastPcSrc = NONE;
  logic memWaiting = 1'b0;
  int heldMemWrite = 0;
  int heldAddr = 0;

  ctrlUnit dut_i (
    .clk(clk), .reset(reset), .opcode(opcode), .funct(funct), .overflow(overflow),
    .eq(eq), .gt(gt), .lt(lt), .memReady(memReady),
    .memValid(memValid), .memWrite(memWrite), .addrFromAlu(addrFromAlu),
    .irWrite(irWrite), .pcWrite(pcWrite), .pcSrc(pcSrc), .regWrite(regWrite),
    .regDst(regDst), .wbSrc(wbSrc), .aluOp(aluOp), .aluSrcA(aluSrcA),
    .aluSrcB(aluSrcB), .epcWrite(epcWrite), .excCause(excCause)
  );

  always #10 clk = ~clk;

  task automatic checkValue(input string name, input int actual, input int expected);
    if (actual != expected) begin
      errorCount++;
      $display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
  endtask

  task automatic waitForFetch();
    @(negedge clk);
    while (!(memValid && !addrFromAlu)) @(negedge clk); // fetch is the only pc-addressed access
  endtask

  task automatic waitForDecode();
    @(negedge clk);
    while (!irWrite) @(negedge clk);
  endtask

  // memory model with ready after 0 to 3 cycles
  always @(negedge clk) begin
    if (reset) begin
      memReady = 1'b0;
      memBusy  = 1'b0;
    end else if (memReady) begin
      memReady = 1'b0; // transfer took place on the last rising edge
      memBusy  = 1'b0;
    end else if (memValid) begin
      if (!memBusy) begin
        memBusy = 1'b1;
        drawBits(2, waitLeft);
      end
      if (waitLeft == 0) begin
        memReady = 1'b1;
      end else begin
        waitLeft--;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (regWrite) begin
        regWriteCount++;
        lastRegDst = int'(regDst);
        lastWbSrc  = int'(wbSrc);
      end
      if (irWrite) begin // decode steps pc by 4
        checkValue("decode pcWrite", int'(pcWrite), 1);
        checkValue("decode pcSrc", int'(pcSrc), int'(pcAluResult));
        checkValue("decode aluOp", int'(aluOp), int'(aluAdd));
        checkValue("decode aluSrcA", int'(aluSrcA), int'(srcAPc));
        checkValue("decode aluSrcB", int'(aluSrcB), int'(srcBFour));
      end
      if (pcWrite && !irWrite) begin // pc + 4 in decode is not counted
        pcWriteCount++;
        lastPcSrc = int'(pcSrc);
      end
      if (epcWrite) begin
        epcWriteCount++;
      end
      if (memValid && memReady && memWrite) begin
        memWriteCount++;
      end
      if (memWaiting) begin
        checkValue("memValid", int'(memValid), 1);
        checkValue("memWrite", int'(memWrite), heldMemWrite);
        checkValue("addrFromAlu", int'(addrFromAlu), heldAddr);
      end
      memWaiting   = memValid && !memReady;
      heldMemWrite = int'(memWrite);
      heldAddr     = int'(addrFromAlu);
    end
  end

  task automatic runCase(input int idx);
    int base;
    int startReg;
    int startPc;
    int startMem;
    int startEpc;
    int errorsBefore;
    base         = 1 + idx * FIELDS;
    errorsBefore = errorCount;
    // DUT is in fetch, so the new fields are decoded only after it
    opcode   = caseMem[base][`OPCODE_W-1:0];
    funct    = caseMem[base + 1][`FUNCT_W-1:0];
    overflow = caseMem[base + 2][0];
    eq       = caseMem[base + 3][0];
    gt       = caseMem[base + 4][0];
    lt       = caseMem[base + 5][0];
    startReg = regWriteCount;
    startPc  = pcWriteCount;
    startMem = memWriteCount;
    startEpc = epcWriteCount;
    waitForDecode();
    waitForFetch();
    checkValue("regWrite count", regWriteCount - startReg, int'(caseMem[base + 6]));
    checkValue("regDst", (regWriteCount == startReg) ? NONE : lastRegDst,
               int'(caseMem[base + 7]));
    checkValue("wbSrc", (regWriteCount == startReg) ? NONE : lastWbSrc,
               int'(caseMem[base + 8]));
    checkValue("pcSrc", (pcWriteCount == startPc) ? NONE : lastPcSrc,
               int'(caseMem[base + 9]));
    checkValue("memWrite count", memWriteCount - startMem, int'(caseMem[base + 10]));
    checkValue("epcWrite count", epcWriteCount - startEpc, int'(caseMem[base + 11]));
    checkValue("excCause", int'(excCause), int'(caseMem[base + 12]));
    if (errorCount == errorsBefore) begin
      $display("case %0d opcode %h funct %h: ok", idx + 1, opcode, funct);
    end else begin
      $display("case %0d opcode %h funct %h: %0d mismatches", idx + 1, opcode, funct,
               errorCount - errorsBefore);
    end
  endtask

  initial begin
    int c;
    reset    = 1'b1;
    opcode   = '0;
    funct    = '0;
    overflow = 1'b0;
    eq       = 1'b0;
    gt       = 1'b0;
    lt       = 1'b0;
    $readmemh("testbench/ctrl_cases.txt", caseMem);
    caseTotal = int'(caseMem[0]);
    loaded    = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // sp write right after reset, then the first fetch
    waitForFetch();
    checkValue("regWrite count", regWriteCount, 1);
    checkValue("regDst", lastRegDst, int'(dstSp));
    checkValue("wbSrc", lastWbSrc, int'(wbStackInit));
    checkValue("pcWrite count", pcWriteCount, 0);
    checkValue("memWrite count", memWriteCount, 0);
    checkValue("epcWrite count", epcWriteCount, 0);
    if (errorCount == 0) begin
      $display("reset: ok");
    end else begin
      $display("reset: %0d mismatches", errorCount);
    end

    if (caseTotal < 1 || caseTotal > MAX_CASES) begin
      errorCount++;
      $display("cases file holds %0d cases, but 1 to %0d are expected", caseTotal, MAX_CASES);
    end else begin
      for (c = 0; c < caseTotal; c++) begin
        runCase(c);
      end
    end

    $display("%0d cases run, %0d errors", caseTotal, errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // no case needs more than 20 cycles
  initial begin
    wait (loaded);
    repeat ((caseTotal + 1) * 20) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped making progress",
             (caseTotal + 1) * 20);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/ctrlUnit.sv */
`default_nettype none

`include "ctrl_params.svh"

module ctrlUnit import ctrlPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`OPCODE_W-1:0] opcode,
  input  logic [`FUNCT_W-1:0]  funct,
  input  logic                 overflow,
  input  logic                 eq,
  input  logic                 gt,
  input  logic                 lt,
  input  logic                 memReady,
  output logic                 memValid,
  output logic                 memWrite,
  output logic                 addrFromAlu,
  output logic                 irWrite,
  output logic                 pcWrite,
  output pcSrcT                pcSrc,
  output logic                 regWrite,
  output regDstT               regDst,
  output wbSrcT                wbSrc,
  output aluOpT                aluOp,
  output aluSrcAT              aluSrcA,
  output aluSrcBT              aluSrcB,
  output logic                 epcWrite,
  output excCauseT             excCause
);

  instrClassT instrClass;
  aluOpT      aluFunct;
  logic       trapsOverflow;
  logic       branchTaken;
  logic       excRaise;
  stateT      state;
  ctrlWordT   ctrl;

  instrDecoder decoder_i (
    .opcode(opcode), .funct(funct), .eq(eq), .gt(gt), .lt(lt),
    .instrClass(instrClass), .aluFunct(aluFunct),
    .trapsOverflow(trapsOverflow), .branchTaken(branchTaken)
  );

  exceptionUnit exc_i (
    .clk(clk), .reset(reset), .state(state), .instrClass(instrClass),
    .trapsOverflow(trapsOverflow), .overflow(overflow),
    .excRaise(excRaise), .excCause(excCause)
  );

  mainFsm fsm_i (
    .clk(clk), .reset(reset), .instrClass(instrClass),
    .excRaise(excRaise), .memReady(memReady), .state(state)
  );

  ctrlWordTable table_i (
    .state(state), .aluFunct(aluFunct), .branchTaken(branchTaken), .ctrl(ctrl)
  );

  assign memValid    = ctrl.memValid;
  assign memWrite    = ctrl.memWrite;
  assign addrFromAlu = ctrl.addrFromAlu;
  assign irWrite     = ctrl.irWrite;
  assign pcWrite     = ctrl.pcWrite;
  assign pcSrc       = ctrl.pcSrc;
  assign regWrite    = ctrl.regWrite;
  assign regDst      = ctrl.regDst;
  assign wbSrc       = ctrl.wbSrc;
  assign aluOp       = ctrl.aluOp;
  assign aluSrcA     = ctrl.aluSrcA;
  assign aluSrcB     = ctrl.aluSrcB;
  assign epcWrite    = ctrl.epcWrite;

endmodule

`default_nettype wire

/* logic/ctrlWordTable.sv */
`default_nettype none

module ctrlWordTable import ctrlPkg::*; (
  input  stateT    state,
  input  aluOpT    aluFunct,
  input  logic     branchTaken,
  output ctrlWordT ctrl
);

  always_comb begin
    ctrl = '{
      memValid: 1'b0, memWrite: 1'b0, addrFromAlu: 1'b0, irWrite: 1'b0,
      pcWrite: 1'b0, pcSrc: pcAluResult, regWrite: 1'b0, regDst: dstRt,
      wbSrc: wbAluResult, aluOp: aluPass, aluSrcA: srcAPc, aluSrcB: srcBRegB,
      epcWrite: 1'b0
    };
    case (state)
      stReset: begin
        ctrl.regWrite = 1'b1; // stack pointer init
        ctrl.regDst   = dstSp;
        ctrl.wbSrc    = wbStackInit;
      end
      stFetch: begin
        ctrl.memValid = 1'b1;
        ctrl.aluOp    = aluAdd;
        ctrl.aluSrcB  = srcBFour;
      end
      stDecode: begin
        ctrl.irWrite = 1'b1;
        ctrl.pcWrite = 1'b1; // pc + 4
        ctrl.aluOp   = aluAdd;
        ctrl.aluSrcB = srcBFour;
      end
      stRegFetch: begin
        ctrl.aluOp   = aluAdd; // branch target into aluOut
        ctrl.aluSrcB = srcBBranchOff;
      end
      stAluExec: begin
        ctrl.aluOp   = aluFunct;
        ctrl.aluSrcA = srcARegA;
      end
      stImmExec: begin
        ctrl.aluOp   = aluFunct;
        ctrl.aluSrcA = srcARegA;
        ctrl.aluSrcB = srcBImmExt;
      end
      stLuiExec: ctrl.aluSrcB = srcBImmExt;
      stAluWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = dstRd;
        ctrl.wbSrc    = (aluFunct == aluCompare) ? wbSltFlag : wbAluResult;
      end
      stImmWrite: begin
        ctrl.regWrite = 1'b1;
        case (aluFunct)
          aluCompare: ctrl.wbSrc = wbSltFlag;
          aluPass:    ctrl.wbSrc = wbLuiImm; // only lui reaches here with pass
          default:    ctrl.wbSrc = wbAluResult;
        endcase
      end
      stBranchExec: begin
        ctrl.aluOp   = aluCompare;
        ctrl.aluSrcA = srcARegA;
        ctrl.pcWrite = branchTaken;
        ctrl.pcSrc   = pcBranchTarget;
      end
      stJump: begin
        ctrl.pcWrite = 1'b1;
        ctrl.pcSrc   = pcJumpTarget;
      end
      stJal: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = dstRa;
        ctrl.wbSrc    = wbPcLink;
      end
      stJr: begin
        ctrl.pcWrite = 1'b1;
        ctrl.pcSrc   = pcRegRs;
      end
      stMemAddr: begin
        ctrl.aluOp   = aluAdd;
        ctrl.aluSrcA = srcARegA;
        ctrl.aluSrcB = srcBImmExt;
      end
      stMemRead: begin
        ctrl.memValid    = 1'b1;
        ctrl.addrFromAlu = 1'b1;
      end
      stMemWrite: begin
        ctrl.memValid    = 1'b1;
        ctrl.memWrite    = 1'b1;
        ctrl.addrFromAlu = 1'b1;
      end
      stLoadWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.wbSrc    = wbMemData;
      end
      stEpcSave: begin
        ctrl.epcWrite = 1'b1;
        ctrl.aluOp    = aluSub; // epc gets pc - 4
        ctrl.aluSrcB  = srcBFour;
      end
      stExcJump: begin
        ctrl.pcWrite = 1'b1;
        ctrl.pcSrc   = pcExcVector;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/mainFsm.sv */
`default_nettype none

`include "ctrl_params.svh"

module mainFsm import ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  instrClassT instrClass,
  input  logic       excRaise,
  input  logic       memReady,
  output stateT      state
);

  stateT nextState;
  logic  isMemState;
  logic  memHold;

  assign isMemState = (state == stFetch) || (state == stMemRead) || (state == stMemWrite);
  assign memHold    = isMemState && !memReady; // back-pressure from memory

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= stReset;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = stFetch;
    if (memHold) begin
      nextState = state;
    end else begin
      case (state)
        stReset:  nextState = stFetch; // after the sp write
        stFetch:  nextState = stDecode;
        stDecode: nextState = stRegFetch;
        stRegFetch: begin
          if (excRaise) begin
            nextState = stEpcSave;
          end else begin
            case (instrClass)
              clsRType:              nextState = stAluExec;
              clsImmArith, clsSlti:  nextState = stImmExec;
              clsLui:                nextState = stLuiExec;
              clsBranch:             nextState = stBranchExec;
              clsJump:               nextState = stJump;
              clsJal:                nextState = stJal;
              clsJr:                 nextState = stJr;
              clsLoad, clsStore:     nextState = stMemAddr;
              default:               nextState = stEpcSave;
            endcase
          end
        end
        stAluExec:  nextState = excRaise ? stEpcSave : stAluWrite;
        stImmExec:  nextState = excRaise ? stEpcSave : stImmWrite;
        stLuiExec:  nextState = stImmWrite;
        stJal:      nextState = stJump; // ra first, then the jump
        stMemAddr:  nextState = (instrClass == clsStore) ? stMemWrite : stMemRead;
        stMemRead:  nextState = stLoadWrite;
        stEpcSave:  nextState = stExcJump;
        // write states, branchExec, jump, jr, memWrite and excJump all end here
        default:    nextState = stFetch;
      endcase
    end
  end

  // memory answers within the budget
  memWaitBound: assert property (@(posedge clk) disable iff (reset)
    isMemState |-> ##[0:`MEM_WAIT_MAX] memReady);

endmodule

`default_nettype wire

/* logic/exceptionUnit.sv */
`default_nettype none

module exceptionUnit import ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  stateT      state,
  input  instrClassT instrClass,
  input  logic       trapsOverflow,
  input  logic       overflow,
  output logic       excRaise,
  output excCauseT   excCause
);

  logic illegalHit;
  logic overflowHit;

  assign illegalHit  = (state == stRegFetch) && (instrClass == clsIllegal);
  assign overflowHit = (state == stAluExec || state == stImmExec) && trapsOverflow && overflow;
  assign excRaise    = illegalHit || overflowHit;

  // cause is captured on the edge into epcSave and held until the next exception
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      excCause <= excNone;
    end else if (excRaise) begin
      excCause <= illegalHit ? excIllegalOp : excOverflow;
    end
  end

  // epcSave runs once, with a cause already latched, and hands over to excJump
  epcSaveOnce: assert property (@(posedge clk) disable iff (reset)
    state == stEpcSave |-> excCause != excNone ##1 state == stExcJump);

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
`default_nettype none

`include "ctrl_params.svh"

module instrDecoder import ctrlPkg::*; (
  input  logic [`OPCODE_W-1:0] opcode,
  input  logic [`FUNCT_W-1:0]  funct,
  input  logic                 eq,
  input  logic                 gt,
  input  logic                 lt,
  output instrClassT           instrClass,
  output aluOpT                aluFunct,
  output logic                 trapsOverflow,
  output logic                 branchTaken
);

  always_comb begin
    instrClass    = clsIllegal;
    aluFunct      = aluPass;
    trapsOverflow = 1'b0;
    case (opcode)
      `OP_RTYPE: begin
        case (funct)
          `FN_ADD: begin
            instrClass    = clsRType;
            aluFunct      = aluAdd;
            trapsOverflow = 1'b1;
          end
          `FN_SUB: begin
            instrClass    = clsRType;
            aluFunct      = aluSub;
            trapsOverflow = 1'b1;
          end
          `FN_AND: begin
            instrClass = clsRType;
            aluFunct   = aluAnd;
          end
          `FN_SLT: begin
            instrClass = clsRType;
            aluFunct   = aluCompare;
          end
          `FN_JR:  instrClass = clsJr;
          default: instrClass = clsIllegal; // shifts, mult/div etc. are not decoded
        endcase
      end
      `OP_ADDI: begin
        instrClass    = clsImmArith;
        aluFunct      = aluAdd;
        trapsOverflow = 1'b1;
      end
      `OP_ADDIU: begin
        instrClass = clsImmArith;
        aluFunct   = aluAdd; // same sum, overflow ignored
      end
      `OP_SLTI: begin
        instrClass = clsSlti;
        aluFunct   = aluCompare;
      end
      `OP_LUI: instrClass = clsLui;
      `OP_BEQ, `OP_BNE, `OP_BLE, `OP_BGT: begin
        instrClass = clsBranch;
        aluFunct   = aluCompare;
      end
      `OP_J:   instrClass = clsJump;
      `OP_JAL: instrClass = clsJal;
      `OP_LW: begin
        instrClass = clsLoad;
        aluFunct   = aluAdd;
      end
      `OP_SW: begin
        instrClass = clsStore;
        aluFunct   = aluAdd;
      end
      default: instrClass = clsIllegal;
    endcase
  end

  // flags come from the compare done in branchExec
  always_comb begin
    case (opcode)
      `OP_BEQ: branchTaken = eq;
      `OP_BNE: branchTaken = !eq;
      `OP_BLE: branchTaken = lt || eq;
      `OP_BGT: branchTaken = gt;
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

  typedef enum logic [4:0] {
    stReset, stFetch, stDecode, stRegFetch,
    stAluExec, stImmExec, stLuiExec, stAluWrite, stImmWrite,
    stBranchExec, stJump, stJal, stJr,
    stMemAddr, stMemRead, stMemWrite, stLoadWrite,
    stEpcSave, stExcJump
  } stateT;

  typedef enum logic [3:0] {
    clsRType, clsImmArith, clsSlti, clsLui, clsBranch, clsJump,
    clsJal, clsJr, clsLoad, clsStore, clsIllegal
  } instrClassT;

  typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluCompare} aluOpT;

  typedef enum logic [1:0] {dstRt, dstRd, dstRa, dstSp} regDstT;

  typedef enum logic [2:0] {
    wbAluResult, wbMemData, wbPcLink, wbLuiImm, wbStackInit, wbSltFlag
  } wbSrcT;

  typedef enum logic [2:0] {
    pcAluResult, pcBranchTarget, pcJumpTarget, pcExcVector, pcRegRs
  } pcSrcT;

  typedef enum logic {srcAPc, srcARegA} aluSrcAT;

  typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImmExt, srcBBranchOff} aluSrcBT;

  typedef enum logic [1:0] {excNone, excIllegalOp, excOverflow} excCauseT;

  // one datapath control word per state
  typedef struct packed {
    logic    memValid;
    logic    memWrite;
    logic    addrFromAlu; // 0 takes the address from pc
    logic    irWrite;
    logic    pcWrite;
    pcSrcT   pcSrc;
    logic    regWrite;
    regDstT  regDst;
    wbSrcT   wbSrc;
    aluOpT   aluOp;
    aluSrcAT aluSrcA;
    aluSrcBT aluSrcB;
    logic    epcWrite;
  } ctrlWordT;

endpackage

`default_nettype wire

/* logic/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W  6

// opcodes
`define OP_RTYPE 6'b000000
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_LUI   6'b001111
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_BLE   6'b000110
`define OP_BGT   6'b000111
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// R-type functs
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_SLT 6'b101010
`define FN_JR  6'b001000

// longest memory wait, in cycles, before the handshake must complete
`define MEM_WAIT_MAX 16

`endif
